//--- verilog/fpu_pkg.sv
package fpu_pkg;

	// opcodes as the CPU decoder emits them.
	localparam logic [3:0] op_fadd = 4'b0011;
	localparam logic [3:0] op_fsub = 4'b0100;
	localparam logic [3:0] op_fmul = 4'b1110;
	localparam logic [3:0] op_fdiv = 4'b1101; // no divider in this core.
	localparam logic [3:0] op_feq = 4'b1100;
	localparam logic [3:0] op_fle = 4'b1011;
	localparam logic [3:0] op_flt = 4'b1010;

	// pipeline depth of each unit in clock cycles.
	localparam logic [2:0] lat_addsub = 3'd3;
	localparam logic [2:0] lat_mul = 3'd2;
	localparam logic [2:0] lat_cmp = 3'd1;

	localparam logic [1:0] unit_addsub = 2'd0;
	localparam logic [1:0] unit_mul = 2'd1;
	localparam logic [1:0] unit_cmp = 2'd2;

	// indexed by the unit selector, entry 3 is unused.
	localparam logic [3:0][2:0] lat_table = {3'd0, lat_cmp, lat_mul, lat_addsub};

	localparam logic [1:0] cmp_eq = 2'd0;
	localparam logic [1:0] cmp_le = 2'd1;
	localparam logic [1:0] cmp_lt = 2'd2;

	// exponent math is done in 10 bits so that bit 9 flags a negative value.
	localparam logic [9:0] exp_bias = 10'd127;
	localparam logic [9:0] exp_max = 10'd255;

	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic sign;
			logic [7:0] exp;
			logic [22:0] frac;
		} f;
	} fp_word_t;

endpackage

//--- verilog/fpu_control.sv
`timescale 1ns/1ps

module fpu_control (
	input logic CLK,
	input logic reset,
	input logic start,
	input logic fpu_en,
	input logic [3:0] alu_op,
	input fpu_pkg::fp_word_t op_a,
	input fpu_pkg::fp_word_t op_b,
	input logic done,
	input fpu_pkg::fp_word_t sum_out,
	input fpu_pkg::fp_word_t prod_out,
	input logic cmp_out,
	output fpu_pkg::fp_word_t opnd_a,
	output fpu_pkg::fp_word_t opnd_b,
	output logic sub_mode,
	output logic [1:0] cmp_op,
	output logic [1:0] unit_sel,
	output logic load,
	output logic dest_float,
	output fpu_pkg::fp_word_t result,
	output logic result_valid
);
	logic busy; // the two states are idle (0) and busy (1).
	logic start_q;
	logic [1:0] sel_q;
	logic supported;
	logic dec_sub;
	logic [1:0] dec_cmp;

	always_comb begin
		supported = 1'b1;
		unit_sel = fpu_pkg::unit_addsub;
		dec_sub = 1'b0;
		dec_cmp = fpu_pkg::cmp_eq;
		dest_float = 1'b1; // only the compares write the integer file.
		case (alu_op)
			fpu_pkg::op_fadd: dec_sub = 1'b0;
			fpu_pkg::op_fsub: dec_sub = 1'b1;
			fpu_pkg::op_fmul: unit_sel = fpu_pkg::unit_mul;
			fpu_pkg::op_fdiv: supported = 1'b0;
			fpu_pkg::op_feq: begin
				unit_sel = fpu_pkg::unit_cmp;
				dest_float = 1'b0;
			end
			fpu_pkg::op_fle: begin
				unit_sel = fpu_pkg::unit_cmp;
				dec_cmp = fpu_pkg::cmp_le;
				dest_float = 1'b0;
			end
			fpu_pkg::op_flt: begin
				unit_sel = fpu_pkg::unit_cmp;
				dec_cmp = fpu_pkg::cmp_lt;
				dest_float = 1'b0;
			end
			default: supported = 1'b0;
		endcase
	end

	// a launch needs a rising start edge seen while idle.
	assign load = !busy && start && !start_q && fpu_en && supported;

	always_ff @(posedge CLK) begin
		if (reset) begin
			start_q <= 1'b0;
			busy <= 1'b0;
			sel_q <= fpu_pkg::unit_addsub;
			result <= '0;
			result_valid <= 1'b0;
		end else begin
			start_q <= start;
			result_valid <= busy && done;
			if (load) begin
				busy <= 1'b1;
				sel_q <= unit_sel;
			end else if (busy && done) begin
				busy <= 1'b0;
				case (sel_q)
					fpu_pkg::unit_mul: result <= prod_out;
					fpu_pkg::unit_cmp: result.raw <= {31'd0, cmp_out};
					default: result <= sum_out;
				endcase
			end
		end
	end

	// operands stay put for the whole operation.
	always_ff @(posedge CLK) begin
		if (load) begin
			opnd_a <= op_a;
			opnd_b <= op_b;
			sub_mode <= dec_sub;
			cmp_op <= dec_cmp;
		end
	end

	assert property (@(posedge CLK) disable iff (reset) result_valid |=> !result_valid);
	// the timer only finishes an operation that this FSM launched.
	assert property (@(posedge CLK) disable iff (reset) done |-> busy);
endmodule

//--- verilog/fpu_latency_timer.sv
`timescale 1ns/1ps

module fpu_latency_timer (
	input logic CLK,
	input logic reset,
	input logic load,
	input logic [1:0] unit_sel,
	output logic done
);
	logic [2:0] count; // zero means idle.

	// one extra count covers the edge that captures the operands.
	always_ff @(posedge CLK) begin
		if (reset) begin
			count <= 3'd0;
		end else if (load) begin
			count <= fpu_pkg::lat_table[unit_sel] + 3'd1;
		end else if (count != 3'd0) begin
			count <= count - 3'd1;
		end
	end

	assign done = (count == 3'd1);

	// the count must fall back to idle right after done.
	assert property (@(posedge CLK) disable iff (reset) done |=> count == 3'd0);
endmodule

//--- verilog/fp_addsub.sv
`timescale 1ns/1ps

module fp_addsub (
	input logic CLK,
	input logic reset,
	input fpu_pkg::fp_word_t opnd_a,
	input fpu_pkg::fp_word_t opnd_b,
	input logic sub_mode,
	output fpu_pkg::fp_word_t sum_out
);
	logic [23:0] mant_a;
	logic [23:0] mant_b;
	logic sign_b;
	logic a_big;
	logic [7:0] exp_diff;
	logic [23:0] small_mant;

	logic s1_sign;
	logic s1_sub;
	logic [7:0] s1_exp;
	logic [23:0] s1_big;
	logic [23:0] s1_small;

	logic s2_sign;
	logic s2_sub;
	logic [7:0] s2_exp;
	logic [24:0] s2_mant;

	logic [4:0] lz;
	logic [23:0] shifted;
	logic [9:0] e_res;
	logic [22:0] norm_frac;

	// stage 1 aligns the smaller operand to the larger one.
	always_comb begin
		mant_a = (opnd_a.f.exp == 8'd0) ? 24'd0 : {1'b1, opnd_a.f.frac}; // subnormals flush.
		mant_b = (opnd_b.f.exp == 8'd0) ? 24'd0 : {1'b1, opnd_b.f.frac};
		sign_b = opnd_b.f.sign ^ sub_mode;
		a_big = {opnd_a.f.exp, mant_a} >= {opnd_b.f.exp, mant_b};
		exp_diff = a_big ? opnd_a.f.exp - opnd_b.f.exp : opnd_b.f.exp - opnd_a.f.exp;
		small_mant = a_big ? mant_b : mant_a;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			s1_sign <= 1'b0;
			s1_sub <= 1'b0;
			s1_exp <= 8'd0;
			s1_big <= 24'd0;
			s1_small <= 24'd0;
		end else begin
			s1_sign <= a_big ? opnd_a.f.sign : sign_b;
			s1_sub <= opnd_a.f.sign ^ sign_b;
			s1_exp <= a_big ? opnd_a.f.exp : opnd_b.f.exp;
			s1_big <= a_big ? mant_a : mant_b;
			s1_small <= small_mant >> exp_diff; // bits shifted out are dropped.
		end
	end

	// stage 2, the larger magnitude keeps the difference non-negative.
	always_ff @(posedge CLK) begin
		if (reset) begin
			s2_sign <= 1'b0;
			s2_sub <= 1'b0;
			s2_exp <= 8'd0;
			s2_mant <= 25'd0;
		end else begin
			s2_sign <= s1_sign;
			s2_sub <= s1_sub;
			s2_exp <= s1_exp;
			if (s1_sub)
				s2_mant <= {1'b0, s1_big} - {1'b0, s1_small};
			else
				s2_mant <= {1'b0, s1_big} + {1'b0, s1_small};
		end
	end

	// stage 3 normalizes the sum.
	always_comb begin
		lz = 5'd0;
		for (int i = 0; i < 24; i++) begin
			if (s2_mant[i])
				lz = 5'(23 - i); // the highest set bit wins.
		end
		shifted = s2_mant[23:0] << lz;
		if (s2_mant[24]) begin
			e_res = {2'b00, s2_exp} + 10'd1;
			norm_frac = s2_mant[23:1];
		end else begin
			e_res = {2'b00, s2_exp} - {5'd0, lz};
			norm_frac = shifted[22:0];
		end
	end

	always_ff @(posedge CLK) begin
		if (reset)
			sum_out <= '0;
		else if (s2_mant == 25'd0)
			sum_out.raw <= {s2_sign & ~s2_sub, 31'd0}; // exact cancellation gives +0.
		else if (e_res[9] || e_res == 10'd0)
			sum_out.raw <= {s2_sign, 31'd0};
		else if (e_res >= fpu_pkg::exp_max)
			sum_out.raw <= {s2_sign, 8'hff, 23'd0};
		else
			sum_out.raw <= {s2_sign, e_res[7:0], norm_frac};
	end
endmodule

//--- verilog/fp_mul.sv
`timescale 1ns/1ps

module fp_mul (
	input logic CLK,
	input logic reset,
	input fpu_pkg::fp_word_t opnd_a,
	input fpu_pkg::fp_word_t opnd_b,
	output fpu_pkg::fp_word_t prod_out
);
	logic [9:0] e_sum;
	logic [47:0] mant_prod;

	logic s1_sign;
	logic s1_zero;
	logic [9:0] s1_exp;
	logic [47:0] s1_prod;

	logic [9:0] e_norm;
	logic [22:0] frac;

	always_comb begin
		e_sum = {2'b00, opnd_a.f.exp} + {2'b00, opnd_b.f.exp} - fpu_pkg::exp_bias;
		mant_prod = {1'b1, opnd_a.f.frac} * {1'b1, opnd_b.f.frac};
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			s1_sign <= 1'b0;
			s1_zero <= 1'b0;
			s1_exp <= 10'd0;
			s1_prod <= 48'd0;
		end else begin
			s1_sign <= opnd_a.f.sign ^ opnd_b.f.sign;
			// zero and subnormal inputs both have a zero exponent.
			s1_zero <= (opnd_a.f.exp == 8'd0) || (opnd_b.f.exp == 8'd0);
			s1_exp <= e_sum;
			s1_prod <= mant_prod;
		end
	end

	// the product of two 1.x mantissas lies in [1, 4).
	always_comb begin
		e_norm = s1_exp + {9'd0, s1_prod[47]};
		frac = s1_prod[47] ? s1_prod[46:24] : s1_prod[45:23];
	end

	always_ff @(posedge CLK) begin
		if (reset)
			prod_out <= '0;
		else if (s1_zero || e_norm[9] || e_norm == 10'd0)
			prod_out.raw <= {s1_sign, 31'd0};
		else if (e_norm >= fpu_pkg::exp_max)
			prod_out.raw <= {s1_sign, 8'hff, 23'd0}; // saturate to infinity.
		else
			prod_out.raw <= {s1_sign, e_norm[7:0], frac};
	end
endmodule

//--- verilog/fp_compare.sv
`timescale 1ns/1ps

module fp_compare (
	input logic CLK,
	input logic reset,
	input fpu_pkg::fp_word_t opnd_a,
	input fpu_pkg::fp_word_t opnd_b,
	input logic [1:0] cmp_op,
	output logic cmp_out
);
	logic both_zero;
	logic is_eq;
	logic is_lt;

	always_comb begin
		both_zero = (opnd_a.raw[30:0] == 31'd0) && (opnd_b.raw[30:0] == 31'd0);
		is_eq = (opnd_a.raw == opnd_b.raw) || both_zero; // +0 and -0 compare equal.
		if (both_zero)
			is_lt = 1'b0;
		else if (opnd_a.raw[31] != opnd_b.raw[31])
			is_lt = opnd_a.raw[31];
		else if (opnd_a.raw[31])
			is_lt = opnd_a.raw[30:0] > opnd_b.raw[30:0]; // larger magnitude is smaller.
		else
			is_lt = opnd_a.raw[30:0] < opnd_b.raw[30:0];
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			cmp_out <= 1'b0;
		end else begin
			case (cmp_op)
				fpu_pkg::cmp_le: cmp_out <= is_lt || is_eq;
				fpu_pkg::cmp_lt: cmp_out <= is_lt;
				default: cmp_out <= is_eq;
			endcase
		end
	end
endmodule

//--- verilog/fpu_core.sv
`timescale 1ns/1ps

module fpu_core (
	input logic CLK,
	input logic reset,
	input logic start,
	input logic fpu_en,
	input logic [3:0] alu_op,
	input fpu_pkg::fp_word_t op_a,
	input fpu_pkg::fp_word_t op_b,
	output logic dest_float,
	output fpu_pkg::fp_word_t result,
	output logic result_valid
);
	fpu_pkg::fp_word_t opnd_a;
	fpu_pkg::fp_word_t opnd_b;
	fpu_pkg::fp_word_t sum_out;
	fpu_pkg::fp_word_t prod_out;
	logic sub_mode;
	logic [1:0] cmp_op;
	logic [1:0] unit_sel;
	logic load;
	logic done;
	logic cmp_out;

	fpu_control u_control (
		.CLK(CLK),
		.reset(reset),
		.start(start),
		.fpu_en(fpu_en),
		.alu_op(alu_op),
		.op_a(op_a),
		.op_b(op_b),
		.done(done),
		.sum_out(sum_out),
		.prod_out(prod_out),
		.cmp_out(cmp_out),
		.opnd_a(opnd_a),
		.opnd_b(opnd_b),
		.sub_mode(sub_mode),
		.cmp_op(cmp_op),
		.unit_sel(unit_sel),
		.load(load),
		.dest_float(dest_float),
		.result(result),
		.result_valid(result_valid)
	);

	fpu_latency_timer u_timer (
		.CLK(CLK),
		.reset(reset),
		.load(load),
		.unit_sel(unit_sel),
		.done(done)
	);

	fp_addsub u_addsub (
		.CLK(CLK),
		.reset(reset),
		.opnd_a(opnd_a),
		.opnd_b(opnd_b),
		.sub_mode(sub_mode),
		.sum_out(sum_out)
	);

	fp_mul u_mul (.CLK(CLK), .reset(reset), .opnd_a(opnd_a), .opnd_b(opnd_b), .prod_out(prod_out));

	fp_compare u_compare (
		.CLK(CLK),
		.reset(reset),
		.opnd_a(opnd_a),
		.opnd_b(opnd_b),
		.cmp_op(cmp_op),
		.cmp_out(cmp_out)
	);
endmodule

//--- testbench/tb_fpu_core.sv
`timescale 1ns/1ps

module tb_fpu_core;
	localparam int num_ops = 110;
	localparam int cycle_limit = num_ops * 8 + 100;

	logic CLK = 1'b0;
	logic reset;
	logic start;
	logic fpu_en;
	logic [3:0] alu_op;
	fpu_pkg::fp_word_t op_a;
	fpu_pkg::fp_word_t op_b;
	logic dest_float;
	fpu_pkg::fp_word_t result;
	logic result_valid;

	logic [31:0] lfsr = 32'h4de5;
	int edges = 0;
	fpu_pkg::fp_word_t exp_q[$];
	string name_q[$];
	int due_q[$];
	fpu_pkg::fp_word_t last_word = '0; // result of the last checked operation.

	fpu_core u_fpu_core (
		.CLK(CLK),
		.reset(reset),
		.start(start),
		.fpu_en(fpu_en),
		.alu_op(alu_op),
		.op_a(op_a),
		.op_b(op_b),
		.dest_float(dest_float),
		.result(result),
		.result_valid(result_valid)
	);

	always #2 CLK = ~CLK;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_word(input string name, input fpu_pkg::fp_word_t expected,
			input fpu_pkg::fp_word_t actual);
		if (actual !== expected)
			fail_run($sformatf("ERR %s expected %h actual %h", name, expected.raw, actual.raw));
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			fail_run($sformatf("ERR %s expected %b actual %b", name, expected, actual));
	endtask

	// galois lfsr, stepped once for every bit handed out.
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
		end
		return bits;
	endfunction

	// an exponent range of 0..0 gives a subnormal.
	function automatic fpu_pkg::fp_word_t rand_float(input int lo, input int hi);
		fpu_pkg::fp_word_t w;
		logic [31:0] r;
		r = next_bits(32);
		w.f.sign = r[31];
		w.f.exp = 8'(lo + (int'(r[30:23]) % (hi - lo + 1)));
		w.f.frac = r[22:0];
		return w;
	endfunction

	function automatic fpu_pkg::fp_word_t pack_trunc(input logic sign, input int e,
			input logic [22:0] frac);
		fpu_pkg::fp_word_t w;
		if (e <= 0)
			w.raw = {sign, 31'd0}; // too small for a normal number.
		else if (e >= 255)
			w.raw = {sign, 8'hff, 23'd0};
		else
			w.raw = {sign, 8'(e), frac};
		return w;
	endfunction

	function automatic fpu_pkg::fp_word_t add_trunc(input fpu_pkg::fp_word_t a,
			input fpu_pkg::fp_word_t b);
		logic [63:0] ma;
		logic [63:0] mb;
		logic [63:0] m;
		logic a_first;
		int e;
		fpu_pkg::fp_word_t w;
		ma = (a.f.exp == 8'd0) ? 64'd0 : {40'd0, 1'b1, a.f.frac};
		mb = (b.f.exp == 8'd0) ? 64'd0 : {40'd0, 1'b1, b.f.frac};
		a_first = (a.f.exp > b.f.exp) || (a.f.exp == b.f.exp && ma >= mb);
		if (a_first)
			mb = mb >> (a.f.exp - b.f.exp);
		else
			ma = ma >> (b.f.exp - a.f.exp);
		if (a.f.sign == b.f.sign)
			m = ma + mb;
		else
			m = a_first ? ma - mb : mb - ma;
		if (m == 64'd0) begin
			w.raw = (a.f.sign == b.f.sign) ? {a.f.sign, 31'd0} : 32'd0;
			return w;
		end
		e = a_first ? int'(a.f.exp) : int'(b.f.exp);
		while (m >= 64'h100_0000) begin
			m = m >> 1;
			e++;
		end
		while (m < 64'h80_0000) begin
			m = m << 1;
			e--;
		end
		return pack_trunc(a_first ? a.f.sign : b.f.sign, e, m[22:0]);
	endfunction

	function automatic fpu_pkg::fp_word_t mul_trunc(input fpu_pkg::fp_word_t a,
			input fpu_pkg::fp_word_t b);
		logic [47:0] p;
		logic sign;
		int e;
		fpu_pkg::fp_word_t w;
		sign = a.f.sign ^ b.f.sign;
		if (a.f.exp == 8'd0 || b.f.exp == 8'd0) begin
			w.raw = {sign, 31'd0};
			return w;
		end
		p = {24'd0, 1'b1, a.f.frac} * {24'd0, 1'b1, b.f.frac};
		e = int'(a.f.exp) + int'(b.f.exp) - 127;
		if (p[47])
			return pack_trunc(sign, e + 1, p[46:24]);
		return pack_trunc(sign, e, p[45:23]);
	endfunction

	// orders sign-magnitude words as integers, -0 lands on +0.
	function automatic longint signed_key(input fpu_pkg::fp_word_t w);
		longint mag;
		mag = longint'({33'd0, w.raw[30:0]});
		return w.f.sign ? -mag : mag;
	endfunction

	function automatic fpu_pkg::fp_word_t fp_ref(input logic [3:0] op,
			input fpu_pkg::fp_word_t a, input fpu_pkg::fp_word_t b);
		fpu_pkg::fp_word_t nb;
		fpu_pkg::fp_word_t w;
		nb = b;
		nb.f.sign = ~b.f.sign;
		w.raw = 32'd0;
		case (op)
			fpu_pkg::op_fadd: w = add_trunc(a, b);
			fpu_pkg::op_fsub: w = add_trunc(a, nb);
			fpu_pkg::op_fmul: w = mul_trunc(a, b);
			fpu_pkg::op_feq: w.raw[0] = signed_key(a) == signed_key(b);
			fpu_pkg::op_fle: w.raw[0] = signed_key(a) <= signed_key(b);
			fpu_pkg::op_flt: w.raw[0] = signed_key(a) < signed_key(b);
			default: w.raw = 32'd0;
		endcase
		return w;
	endfunction

	task automatic issue_op(input string name, input logic [3:0] op,
			input fpu_pkg::fp_word_t a, input fpu_pkg::fp_word_t b, input int hold);
		int e2e;
		logic is_cmp;
		is_cmp = (op == fpu_pkg::op_feq || op == fpu_pkg::op_fle || op == fpu_pkg::op_flt);
		e2e = (op == fpu_pkg::op_fmul) ? 3 : (is_cmp ? 2 : 4);
		@(posedge CLK);
		start <= 1'b1;
		fpu_en <= 1'b1;
		alu_op <= op;
		op_a <= a;
		op_b <= b;
		exp_q.push_back(fp_ref(op, a, b));
		name_q.push_back(name);
		due_q.push_back(edges + e2e + 2); // edges has not counted this edge yet.
		@(negedge CLK);
		check_bit({name, " dest_float"}, !is_cmp, dest_float);
		repeat (hold) @(posedge CLK);
		start <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge CLK);
	endtask

	// a start edge that must not launch anything.
	task automatic expect_silence(input string name, input logic [3:0] op, input logic en);
		@(posedge CLK);
		start <= 1'b1;
		fpu_en <= en;
		alu_op <= op;
		op_a <= rand_float(1, 254);
		op_b <= rand_float(1, 254);
		repeat (2) @(posedge CLK);
		start <= 1'b0;
		repeat (6) @(posedge CLK);
		fpu_en <= 1'b1;
		@(negedge CLK);
		check_word({name, " hold"}, last_word, result);
	endtask

	always @(posedge CLK) begin
		edges <= edges + 1;
		if (edges >= cycle_limit)
			fail_run($sformatf("the run did not finish within %0d cycles", cycle_limit));
	end

	always @(negedge CLK) begin
		if (!reset) begin
			if (result_valid) begin
				if (exp_q.size() == 0) begin
					fail_run("result_valid pulsed while no operation was outstanding");
				end else if (edges != due_q[0]) begin
					fail_run($sformatf("%s result came at edge %0d instead of edge %0d",
						name_q[0], edges, due_q[0]));
				end else begin
					check_word(name_q[0], exp_q[0], result);
					last_word = exp_q.pop_front();
					void'(name_q.pop_front());
					void'(due_q.pop_front());
				end
			end else if (exp_q.size() != 0 && edges >= due_q[0]) begin
				fail_run($sformatf("no result_valid pulse for %s by edge %0d", name_q[0], edges));
			end
		end
	end

	initial begin
		fpu_pkg::fp_word_t a;
		fpu_pkg::fp_word_t b;
		logic [3:0] op;
		reset = 1'b1;
		start = 1'b0;
		fpu_en = 1'b0;
		alu_op = 4'd0;
		op_a = '0;
		op_b = '0;
		repeat (4) @(posedge CLK);
		reset <= 1'b0;

		for (int i = 0; i < 30; i++) begin
			op = i[0] ? fpu_pkg::op_fsub : fpu_pkg::op_fadd;
			issue_op($sformatf("addsub %0d", i), op, rand_float(100, 140), rand_float(100, 140), 1);
		end
		a = rand_float(1, 254);
		b = a;
		b.f.sign = ~a.f.sign;
		issue_op("sub cancel", fpu_pkg::op_fsub, a, a, 1);
		issue_op("add cancel", fpu_pkg::op_fadd, a, b, 1);
		a = rand_float(254, 254);
		issue_op("add overflow", fpu_pkg::op_fadd, a, a, 1);

		for (int i = 0; i < 20; i++)
			issue_op($sformatf("mul %0d", i), fpu_pkg::op_fmul, rand_float(64, 190),
				rand_float(64, 190), 1);
		for (int i = 0; i < 5; i++) begin
			issue_op($sformatf("mul under %0d", i), fpu_pkg::op_fmul, rand_float(1, 60),
				rand_float(1, 60), 1);
			issue_op($sformatf("mul over %0d", i), fpu_pkg::op_fmul, rand_float(200, 254),
				rand_float(200, 254), 1);
		end

		for (int i = 0; i < 30; i++) begin
			op = (i % 3 == 0) ? fpu_pkg::op_feq : ((i % 3 == 1) ? fpu_pkg::op_fle : fpu_pkg::op_flt);
			issue_op($sformatf("cmp %0d", i), op, rand_float(120, 130), rand_float(120, 130), 1);
		end
		a = rand_float(1, 254);
		b.raw = 32'h8000_0000;
		issue_op("feq same", fpu_pkg::op_feq, a, a, 1);
		issue_op("fle same", fpu_pkg::op_fle, a, a, 1);
		issue_op("flt same", fpu_pkg::op_flt, a, a, 1);
		issue_op("feq zeros", fpu_pkg::op_feq, '0, b, 1);
		issue_op("fle zeros", fpu_pkg::op_fle, b, '0, 1);
		issue_op("flt zeros", fpu_pkg::op_flt, '0, b, 1);

		a = rand_float(0, 0);
		b = rand_float(1, 254);
		issue_op("add subnormal b", fpu_pkg::op_fadd, b, a, 1);
		issue_op("add subnormal a", fpu_pkg::op_fadd, a, b, 1);
		issue_op("mul subnormal one", fpu_pkg::op_fmul, a, 32'h3f80_0000, 1);
		issue_op("mul subnormal minus one", fpu_pkg::op_fmul, a, 32'hbf80_0000, 1);

		expect_silence("fdiv", fpu_pkg::op_fdiv, 1'b1);
		expect_silence("opcode 0000", 4'b0000, 1'b1);
		expect_silence("opcode 1111", 4'b1111, 1'b1);
		expect_silence("fpu_en low", fpu_pkg::op_fadd, 1'b0);
		issue_op("held start", fpu_pkg::op_fadd, rand_float(100, 140), rand_float(100, 140), 8);
		expect_silence("after held start", 4'b0000, 1'b1);

		// the second start edge lands while the add is still in flight.
		a = rand_float(100, 140);
		b = rand_float(100, 140);
		@(posedge CLK);
		start <= 1'b1;
		alu_op <= fpu_pkg::op_fadd;
		op_a <= a;
		op_b <= b;
		exp_q.push_back(fp_ref(fpu_pkg::op_fadd, a, b));
		name_q.push_back("busy add");
		due_q.push_back(edges + 6);
		@(posedge CLK);
		start <= 1'b0;
		@(posedge CLK);
		start <= 1'b1;
		alu_op <= fpu_pkg::op_fmul;
		op_a <= b;
		@(posedge CLK);
		start <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge CLK);
		repeat (6) @(posedge CLK);
		@(negedge CLK);
		check_word("busy add hold", last_word, result); // the ignored start must not overwrite it.

		$display("TEST RESULT: PASS");
		$finish;
	end
endmodule

//--- fpu_core.f
verilog/fpu_pkg.sv
verilog/fpu_control.sv
verilog/fpu_latency_timer.sv
verilog/fp_addsub.sv
verilog/fp_mul.sv
verilog/fp_compare.sv
verilog/fpu_core.sv
testbench/tb_fpu_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_fpu_core
FILELIST ?= fpu_core.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)
